//--- compile.f
src/dsi_pkt_pkg.sv
src/dsi_cfg_pkg.sv
src/dsi_crc16.sv
src/dsi_apb_regs.sv
src/dsi_frame_sequencer.sv
src/dsi_cmd_fifo.sv
src/dsi_packet_builder.sv
src/dsi_lane_repacker.sv
src/dsi_tx_top.sv
sim/tb_clock_gen.sv
sim/dsi_tx_chk.sv
sim/dsi_tx_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dsi_tx_tb \
    -f compile.f --Mdir obj_dir -o dsi_tx_sim

out=$(./obj_dir/dsi_tx_sim 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST PASSED"

//--- sim/dsi_tx_chk.sv
`timescale 1ns/1ps

module dsi_tx_chk
    import dsi_cfg_pkg::*;
(
    input logic                 clk,
    input logic                 rst_n,
    input apb_req_t             apb_req,
    input apb_rsp_t             apb_rsp,
    input logic                 pix_ready,
    input logic [MAX_LANES-1:0] lane_write,
    input logic [MAX_LANES-1:0] lane_full,
    input logic [2:0]           lane_count,
    input logic                 stream_enable
);

    int   assert_fails = 0;
    logic enabled_once;  // stream enabled at least once since reset

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            enabled_once <= 1'b0;
        else if (stream_enable)
            enabled_once <= 1'b1;
    end

    full_blocks_write: assert property (@(posedge clk) disable iff (!rst_n)
        (|lane_full) |-> (lane_write == '0))
    else
    begin
        assert_fails++;
        $error("lane write while a lane reports full");
    end

    // run of ones from lane 0, no wider than the lane count
    write_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        ((lane_write & (lane_write + 4'd1)) == 4'd0) && ($countones(lane_write) <= lane_count))
    else
    begin
        assert_fails++;
        $error("lane_write %b not contiguous within %0d lanes", lane_write, lane_count);
    end

    apb_no_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
    else
    begin
        assert_fails++;
        $error("pready low in the APB access phase");
    end

    pix_idle_until_enable: assert property (@(posedge clk) disable iff (!rst_n)
        pix_ready |-> (enabled_once || stream_enable))
    else
    begin
        assert_fails++;
        $error("pix_ready raised before the stream was enabled");
    end

endmodule

//--- sim/dsi_tx_tb.sv
`timescale 1ns/1ps

module dsi_tx_tb
    import dsi_cfg_pkg::*;
();

    typedef logic [7:0] byte_q_t [$];

    typedef struct packed {
        logic [2:0]  lanes;
        logic [15:0] hbp;
        logic [15:0] hfp;
        logic [15:0] lblank;
        logic [15:0] pixels;
        logic [15:0] vbp;
        logic [15:0] active;
        logic [15:0] vfp;
        logic [6:0]  full_pct;   // lane_full probability
        logic [6:0]  stall_pct;  // pixel source stall probability
        logic [7:0]  bad_addr;
    } row_t;

    localparam int NUM_ROWS = 4;
    localparam row_t ROWS [NUM_ROWS] = '{
        '{3'd1, 16'd2, 16'd3, 16'd5, 16'd3, 16'd1, 16'd2, 16'd1, 7'd25, 7'd20, 8'h20},
        '{3'd2, 16'd4, 16'd1, 16'd6, 16'd2, 16'd0, 16'd3, 16'd1, 7'd20, 7'd30, 8'h24},
        '{3'd3, 16'd5, 16'd0, 16'd3, 16'd5, 16'd2, 16'd1, 16'd0, 7'd30, 7'd25, 8'h03},
        '{3'd4, 16'd1, 16'd4, 16'd7, 16'd4, 16'd1, 16'd3, 16'd2, 7'd40, 7'd40, 8'hFC}
    };

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req = '0;
    apb_rsp_t    apb_rsp;
    logic [31:0] pix_data = 32'h0302_0100;
    logic        pix_valid = 1'b0;
    logic        pix_ready;
    logic [31:0] lane_data;
    logic [3:0]  lane_write;
    logic [3:0]  lane_full = 4'd0;

    int          seed = 89985;
    int unsigned cur_full = 0;
    int unsigned cur_stall = 0;
    int unsigned pix_word = 0;     // next pixel word offered
    int unsigned model_word = 0;   // pixel words used by the model
    int unsigned cycles = 0;
    int unsigned cycle_limit = 32'hFFFF_FFFF;
    int          mismatch_count = 0;
    int          fail_count = 0;
    byte_q_t     exp_q;
    byte_q_t     got_q;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .rst_n(rst_n));

    dsi_tx_top i_dsi_tx_top (
        .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .pix_data(pix_data), .pix_valid(pix_valid), .pix_ready(pix_ready),
        .lane_data(lane_data), .lane_write(lane_write), .lane_full(lane_full)
    );

    bind dsi_tx_top dsi_tx_chk i_dsi_tx_chk (
        .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .pix_ready(pix_ready), .lane_write(lane_write), .lane_full(lane_full),
        .lane_count(lane_count), .stream_enable(stream_enable)
    );

    // pixel source with counting bytes, random stalls and lane_full
    always @(posedge clk)
    begin : stimulus_gen
        int unsigned nxt;
        int unsigned roll;
        nxt = (pix_valid && pix_ready) ? pix_word + 1 : pix_word;
        pix_word <= nxt;
        pix_data <= {8'(4 * nxt + 3), 8'(4 * nxt + 2), 8'(4 * nxt + 1), 8'(4 * nxt)};
        roll = $unsigned($random(seed)) % 100;
        if (!pix_valid || pix_ready)
            pix_valid <= (roll >= cur_stall);  // hold until taken
        roll = $unsigned($random(seed)) % 100;
        lane_full <= (roll < cur_full) ? (4'b0001 << (roll % 4)) : 4'd0;
    end

    // lane monitor, bytes in lane order
    always @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
            if (lane_write[i])
                got_q.push_back(lane_data[8*i +: 8]);
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            fail_count++;
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic void print_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, fail_count, i_dsi_tx_top.i_dsi_tx_chk.assert_fails);
    endfunction

    function automatic void report_mismatch(input string sig, input logic [31:0] exp,
                                            input logic [31:0] act);
        mismatch_count++;
        $display("Mismatch at %0t: %s expected %0h, got %0h", $time, sig, exp, act);
    endfunction

    function automatic logic [7:0] ref_ecc(input logic [23:0] d);
        logic [7:0] e;
        e = 8'd0;
        e[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
        e[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
        e[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
        e[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
        e[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
        e[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
        return e;
    endfunction

    // ccitt crc, reflected, seed ffff
    function automatic logic [15:0] ref_crc(input byte_q_t pl);
        logic [15:0] c;
        c = 16'hFFFF;
        foreach (pl[i])
        begin
            c = c ^ {8'd0, pl[i]};
            for (int k = 0; k < 8; k++)
                c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
        end
        return c;
    endfunction

    function automatic void add_header(input logic [5:0] dt, input logic [15:0] field);
        logic [23:0] h;
        h = {field, 2'b00, dt};
        exp_q.push_back(h[7:0]);
        exp_q.push_back(h[15:8]);
        exp_q.push_back(h[23:16]);
        exp_q.push_back(ref_ecc(h));
    endfunction

    function automatic void add_long(input logic [5:0] dt, input byte_q_t pl);
        logic [15:0] c;
        c = ref_crc(pl);
        add_header(dt, 16'(pl.size()));
        foreach (pl[i])
            exp_q.push_back(pl[i]);
        exp_q.push_back(c[7:0]);
        exp_q.push_back(c[15:8]);
    endfunction

    function automatic void add_blank(input logic [15:0] n);
        byte_q_t pl;
        repeat (n) pl.push_back(8'h55);
        add_long(6'h19, pl);
    endfunction

    function automatic void add_pixels(input logic [15:0] npix);
        byte_q_t pl;
        int      n;
        n = 3 * npix;
        for (int i = 0; i < n; i++)
            pl.push_back(8'(4 * model_word + i));
        model_word += (n + 3) / 4;  // tail of last word dropped
        add_long(6'h3E, pl);
    endfunction

    function automatic void build_frame(input row_t r);
        add_header(6'h01, 16'd0);  // VSS
        add_blank(r.lblank);
        for (int l = 0; l < r.vbp; l++)
        begin
            add_header(6'h21, 16'd0);
            add_blank(r.lblank);
        end
        for (int l = 0; l < r.active; l++)
        begin
            add_header(6'h21, 16'd0);
            add_blank(r.hbp);
            add_pixels(r.pixels);
            add_blank(r.hfp);
        end
        for (int l = 0; l < r.vfp; l++)
        begin
            add_header(6'h21, 16'd0);
            add_blank(r.lblank);
        end
    endfunction

    task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        apb_req.paddr <= addr;
        apb_req.pwrite <= wr;
        apb_req.pwdata <= wdata;
        apb_req.psel <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clk);
        apb_req.psel <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b1, data, rdata, err);
        if (err)
        begin
            fail_count++;
            $display("pslverr on write to mapped address %02h", addr);
        end
    endtask

    task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b0, 32'd0, rdata, err);
        if (err)
        begin
            fail_count++;
            $display("pslverr on read from mapped address %02h", addr);
        end
        if (rdata !== exp)
            report_mismatch($sformatf("prdata[%02h]", addr), exp, rdata);
    endtask

    task automatic check_reset_and_clamp();
        for (int a = 4; a <= 28; a += 4)
            expect_reg(8'(a), 32'd0);
        expect_reg(REG_CTRL, 32'h2);  // lane_count resets to 1
        write_reg(REG_CTRL, 32'h0);
        expect_reg(REG_CTRL, 32'h2);
        write_reg(REG_CTRL, 32'hE);
        expect_reg(REG_CTRL, 32'h8);  // seven clamps to four
    endtask

    task automatic run_row(input int idx, input row_t r);
        logic [7:0]  addr [7];
        logic [15:0] val [7];
        logic [31:0] rdata;
        logic        err;
        addr = '{REG_HBP, REG_HFP, REG_LBLANK, REG_PIXELS, REG_VBP, REG_ACTIVE, REG_VFP};
        val = '{r.hbp, r.hfp, r.lblank, r.pixels, r.vbp, r.active, r.vfp};
        cur_full = r.full_pct;
        cur_stall = r.stall_pct;
        for (int i = 0; i < 7; i++)
        begin
            write_reg(addr[i], {16'd0, val[i]});
            expect_reg(addr[i], {16'd0, val[i]});
        end
        write_reg(REG_CTRL, {28'd0, r.lanes, 1'b0});
        expect_reg(REG_CTRL, {28'd0, r.lanes, 1'b0});
        apb_access(r.bad_addr, 1'b1, 32'hDEAD_BEEF, rdata, err);
        if (!err)
        begin
            fail_count++;
            $display("no pslverr on write to unmapped address %02h", r.bad_addr);
        end
        apb_access(r.bad_addr, 1'b0, 32'd0, rdata, err);
        if (!err)
        begin
            fail_count++;
            $display("no pslverr on read from unmapped address %02h", r.bad_addr);
        end
        for (int i = 0; i < 7; i++)
            expect_reg(addr[i], {16'd0, val[i]});
        expect_reg(REG_CTRL, {28'd0, r.lanes, 1'b0});

        exp_q.delete();
        got_q.delete();
        build_frame(r);
        write_reg(REG_CTRL, {28'd0, r.lanes, 1'b1});
        while (got_q.size() == 0)
            @(posedge clk);
        write_reg(REG_CTRL, {28'd0, r.lanes, 1'b0});  // one frame only
        while (got_q.size() < exp_q.size())
            @(posedge clk);
        repeat (16) @(posedge clk);  // room for stray bytes
        if (got_q.size() != exp_q.size())
        begin
            fail_count++;
            $display("row %0d: %0d lane bytes received, %0d expected",
                     idx, got_q.size(), exp_q.size());
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
            if (got_q[i] !== exp_q[i])
                report_mismatch($sformatf("lane_data byte %0d row %0d", i, idx),
                                exp_q[i], got_q[i]);
    endtask

    initial
    begin
        int unsigned total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            exp_q.delete();
            build_frame(ROWS[i]);
            total += exp_q.size();
        end
        cycle_limit = 4 * total + 2000;
        model_word = 0;

        @(posedge rst_n);
        check_reset_and_clamp();
        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i, ROWS[i]);

        print_counts();
        if (mismatch_count == 0 && fail_count == 0 && i_dsi_tx_top.i_dsi_tx_chk.assert_fails == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 4;  // 8 ns clock
    localparam int RESET_CYCLES = 16;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- src/dsi_apb_regs.sv
`timescale 1ns/1ps

module dsi_apb_regs
    import dsi_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output dsi_timing_t timing,
    output logic        stream_enable,
    output logic [2:0]  lane_count
);

    logic        access;
    logic        hit;
    logic [31:0] rdata;
    logic [2:0]  lanes_in;
    logic [2:0]  lanes_clamped;

    assign access = apb_req.psel && apb_req.penable;  // access phase
    assign lanes_in = apb_req.pwdata[3:1];
    assign lanes_clamped = (lanes_in == 3'd0) ? 3'd1 :
                           (lanes_in > 3'(MAX_LANES)) ? 3'(MAX_LANES) : lanes_in;

    always_comb
    begin
        hit = 1'b1;
        rdata = 32'd0;
        case (apb_req.paddr)
            REG_CTRL:   rdata = {28'd0, lane_count, stream_enable};
            REG_HBP:    rdata = {16'd0, timing.hbp_bytes};
            REG_HFP:    rdata = {16'd0, timing.hfp_bytes};
            REG_LBLANK: rdata = {16'd0, timing.line_blank_bytes};
            REG_PIXELS: rdata = {16'd0, timing.pixels_per_line};
            REG_VBP:    rdata = {16'd0, timing.vbp_lines};
            REG_ACTIVE: rdata = {16'd0, timing.active_lines};
            REG_VFP:    rdata = {16'd0, timing.vfp_lines};
            default:    hit = 1'b0;  // unmapped
        endcase
    end

    assign apb_rsp.prdata = (access && !apb_req.pwrite) ? rdata : 32'd0;
    assign apb_rsp.pready = 1'b1;  // no wait states
    assign apb_rsp.pslverr = access && !hit;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stream_enable <= 1'b0;
            lane_count <= 3'd1;
            timing <= '0;
        end
        else if (access && apb_req.pwrite)
        begin
            case (apb_req.paddr)
                REG_CTRL:
                begin
                    stream_enable <= apb_req.pwdata[0];
                    lane_count <= lanes_clamped;
                end
                REG_HBP:    timing.hbp_bytes <= apb_req.pwdata[15:0];
                REG_HFP:    timing.hfp_bytes <= apb_req.pwdata[15:0];
                REG_LBLANK: timing.line_blank_bytes <= apb_req.pwdata[15:0];
                REG_PIXELS: timing.pixels_per_line <= apb_req.pwdata[15:0];
                REG_VBP:    timing.vbp_lines <= apb_req.pwdata[15:0];
                REG_ACTIVE: timing.active_lines <= apb_req.pwdata[15:0];
                REG_VFP:    timing.vfp_lines <= apb_req.pwdata[15:0];
                default:    ;  // registers untouched
            endcase
        end
    end

endmodule

//--- src/dsi_cfg_pkg.sv
package dsi_cfg_pkg;

    localparam int MAX_LANES = 4;

    localparam logic [7:0] REG_CTRL   = 8'h00;  // bit 0 enable, bits 3:1 lanes
    localparam logic [7:0] REG_HBP    = 8'h04;
    localparam logic [7:0] REG_HFP    = 8'h08;
    localparam logic [7:0] REG_LBLANK = 8'h0C;
    localparam logic [7:0] REG_PIXELS = 8'h10;
    localparam logic [7:0] REG_VBP    = 8'h14;
    localparam logic [7:0] REG_ACTIVE = 8'h18;
    localparam logic [7:0] REG_VFP    = 8'h1C;

    // blanking sizes are byte counts of the payload
    typedef struct packed {
        logic [15:0] hbp_bytes;
        logic [15:0] hfp_bytes;
        logic [15:0] line_blank_bytes;
        logic [15:0] pixels_per_line;
        logic [15:0] vbp_lines;
        logic [15:0] active_lines;
        logic [15:0] vfp_lines;
    } dsi_timing_t;

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

//--- src/dsi_cmd_fifo.sv
`timescale 1ns/1ps

module dsi_cmd_fifo
    import dsi_pkt_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  pkt_cmd_t in_cmd,
    input  logic     in_valid,
    output logic     in_ready,
    output pkt_cmd_t out_cmd,
    output logic     out_valid,
    input  logic     out_ready
);

    pkt_cmd_t   mem [4];
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] count;
    logic       push;
    logic       pop;

    assign in_ready = !count[2];  // full at four entries
    assign out_valid = (count != 3'd0);
    assign out_cmd = mem[rd_ptr];
    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_cmd;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= 2'd0;
            rd_ptr <= 2'd0;
            count <= 3'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 2'd1;
            if (pop)
                rd_ptr <= rd_ptr + 2'd1;
            count <= count + 3'(push) - 3'(pop);
        end
    end

endmodule

//--- src/dsi_crc16.sv
`timescale 1ns/1ps

module dsi_crc16
    import dsi_pkt_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        seed,
    input  logic        update,
    input  logic [31:0] data,
    input  logic [2:0]  nbytes,
    output logic [15:0] crc
);

    logic [15:0] crc_next;
    logic        fb;

    // lsb-first shift, byte 0 first
    always_comb
    begin
        crc_next = crc;
        fb = 1'b0;
        for (int b = 0; b < 4; b++)
        begin
            if (b < nbytes)
            begin
                for (int i = 0; i < 8; i++)
                begin
                    fb = crc_next[0] ^ data[8*b+i];
                    crc_next = {1'b0, crc_next[15:1]} ^ (fb ? CRC_POLY : 16'h0000);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc <= CRC_INIT;
        else if (seed)
            crc <= CRC_INIT;
        else if (update)
            crc <= crc_next;
    end

endmodule

//--- src/dsi_frame_sequencer.sv
`timescale 1ns/1ps

module dsi_frame_sequencer
    import dsi_pkt_pkg::*, dsi_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  dsi_timing_t timing,
    input  logic        stream_enable,
    output pkt_cmd_t    cmd,
    output logic        cmd_valid,
    input  logic        cmd_ready
);

    typedef enum logic [2:0] {IDLE, VSS, VSS_BL, SYNC, HBP, RGB, HFP, LINE_BL} state_e;
    typedef enum logic [1:0] {R_VBP, R_ACT, R_VFP, R_END} region_e;

    state_e      state;
    region_e     region;
    region_e     from_region;
    region_e     new_region;
    logic [15:0] lines_left;
    logic [15:0] new_lines;
    logic        fire;

    assign cmd_valid = (state != IDLE);
    assign fire = cmd_valid && cmd_ready;

    // first non-empty vertical region at or after from_region
    always_comb
    begin
        from_region = (state == VSS_BL) ? R_VBP : region_e'(region + 2'd1);
        new_region = R_END;
        new_lines = 16'd0;
        if (from_region == R_VBP && timing.vbp_lines != 16'd0)
        begin
            new_region = R_VBP;
            new_lines = timing.vbp_lines;
        end
        else if (from_region <= R_ACT && timing.active_lines != 16'd0)
        begin
            new_region = R_ACT;
            new_lines = timing.active_lines;
        end
        else if (from_region <= R_VFP && timing.vfp_lines != 16'd0)
        begin
            new_region = R_VFP;
            new_lines = timing.vfp_lines;
        end
    end

    always_comb
    begin
        cmd = '0;
        case (state)
            VSS:  cmd.hdr.short_h.dt = DT_VSS;
            SYNC: cmd.hdr.short_h.dt = DT_HSS;
            VSS_BL, LINE_BL, HBP, HFP:
            begin
                cmd.hdr.long_h.dt = DT_BLANK;
                cmd.is_long = 1'b1;
                cmd.hdr.long_h.wc = (state == HBP) ? timing.hbp_bytes :
                                    (state == HFP) ? timing.hfp_bytes : timing.line_blank_bytes;
            end
            RGB:
            begin
                cmd.hdr.long_h.dt = DT_PPS24;
                cmd.hdr.long_h.wc = 16'(timing.pixels_per_line * 16'd3);  // 3 bytes per pixel
                cmd.is_long = 1'b1;
                cmd.pixels = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            region <= R_VBP;
            lines_left <= 16'd0;
        end
        else
        begin
            case (state)
                IDLE: if (stream_enable) state <= VSS;
                VSS:  if (fire) state <= VSS_BL;
                SYNC: if (fire) state <= (region == R_ACT) ? HBP : LINE_BL;
                HBP:  if (fire) state <= RGB;
                RGB:  if (fire) state <= HFP;
                VSS_BL, HFP, LINE_BL:
                    if (fire)
                    begin
                        if (state != VSS_BL && lines_left > 16'd1)
                        begin
                            lines_left <= lines_left - 16'd1;
                            state <= SYNC;
                        end
                        else if (new_region != R_END)
                        begin
                            region <= new_region;
                            lines_left <= new_lines;
                            state <= SYNC;
                        end
                        else
                            state <= stream_enable ? VSS : IDLE;  // frame boundary
                    end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- src/dsi_lane_repacker.sv
`timescale 1ns/1ps

module dsi_lane_repacker
    import dsi_pkt_pkg::*, dsi_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [2:0]             lane_count,
    input  word_t                  word,
    input  logic                   word_valid,
    output logic                   word_ready,
    output logic [8*MAX_LANES-1:0] lane_data,
    output logic [MAX_LANES-1:0]   lane_write,
    input  logic [MAX_LANES-1:0]   lane_full
);

    logic [63:0] shadow;  // oldest byte in bits 7:0
    logic [3:0]  count;
    logic [3:0]  out_n;
    logic [3:0]  pop_n;
    logic [3:0]  remain;
    logic [63:0] word_bits;
    logic        write;
    logic        accept;

    assign write = (count != 4'd0) && !(|lane_full);
    assign out_n = (count < 4'(lane_count)) ? count : 4'(lane_count);
    assign pop_n = write ? out_n : 4'd0;
    assign remain = count - pop_n;

    assign word_ready = (4'd8 - count) >= 4'(word.nbytes);  // free space holds the word
    assign accept = word_valid && word_ready;
    // unused upper bytes cleared so the buffer tail stays zero
    assign word_bits = {32'd0, word.data} & ~(64'hFFFF_FFFF_FFFF_FFFF << (8 * word.nbytes));

    assign lane_data = shadow[8*MAX_LANES-1:0];
    assign lane_write = write ? 4'((5'd1 << out_n) - 5'd1) : 4'd0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shadow <= 64'd0;
            count <= 4'd0;
        end
        else
        begin
            if (accept)
                shadow <= (shadow >> (8 * pop_n)) | (word_bits << (8 * remain));
            else
                shadow <= shadow >> (8 * pop_n);
            count <= remain + (accept ? 4'(word.nbytes) : 4'd0);
        end
    end

endmodule

//--- src/dsi_packet_builder.sv
`timescale 1ns/1ps

module dsi_packet_builder
    import dsi_pkt_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  pkt_cmd_t    cmd,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  logic [31:0] pix_data,
    input  logic        pix_valid,
    output logic        pix_ready,
    output word_t       word,
    output logic        word_valid,
    input  logic        word_ready
);

    typedef enum logic [1:0] {HEADER, PAYLOAD, CRC} state_e;

    state_e      state;
    logic [15:0] bytes_left;
    logic        pix_pkt;
    logic [23:0] hdr_bytes;
    logic [7:0]  ecc;
    logic [2:0]  pay_bytes;
    logic        accept;
    logic [15:0] crc;

    // same bit layout in both views, DI byte lowest
    assign hdr_bytes = cmd.hdr;

    assign ecc = dsi_ecc(hdr_bytes);
    assign pay_bytes = (bytes_left >= 16'd4) ? 3'd4 : bytes_left[2:0];
    assign accept = word_valid && word_ready;
    assign cmd_ready = (state == HEADER) && word_ready;  // pop with header word
    assign pix_ready = (state == PAYLOAD) && pix_pkt && word_ready;

    always_comb
    begin
        word = '0;
        word_valid = 1'b0;
        case (state)
            HEADER:
            begin
                word_valid = cmd_valid;
                word.data = {ecc, hdr_bytes};
                word.nbytes = 3'd4;
            end
            PAYLOAD:
            begin
                word_valid = pix_pkt ? pix_valid : 1'b1;
                word.data = pix_pkt ? pix_data : {4{BLANK_BYTE}};
                word.nbytes = pay_bytes;  // short on the last word
            end
            CRC:
            begin
                word_valid = 1'b1;
                word.data = {16'd0, crc};  // low byte first
                word.nbytes = 3'd2;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= HEADER;
            bytes_left <= 16'd0;
            pix_pkt <= 1'b0;
        end
        else if (accept)
        begin
            case (state)
                HEADER:
                    if (cmd.is_long)
                    begin
                        bytes_left <= cmd.hdr.long_h.wc;
                        pix_pkt <= cmd.pixels;
                        state <= (cmd.hdr.long_h.wc == 16'd0) ? CRC : PAYLOAD;
                    end
                PAYLOAD:
                begin
                    bytes_left <= bytes_left - 16'(pay_bytes);
                    if (bytes_left <= 16'd4)
                        state <= CRC;
                end
                default: state <= HEADER;
            endcase
        end
    end

    dsi_crc16 i_dsi_crc16 (
        .clk    (clk),
        .rst_n  (rst_n),
        .seed   (accept && state == HEADER),
        .update (accept && state == PAYLOAD),
        .data   (word.data),
        .nbytes (word.nbytes),
        .crc    (crc)
    );

endmodule

//--- src/dsi_pkt_pkg.sv
package dsi_pkt_pkg;

    typedef enum logic [5:0] {
        DT_VSS   = 6'h01,
        DT_HSS   = 6'h21,
        DT_BLANK = 6'h19,
        DT_PPS24 = 6'h3E
    } dsi_dt_e;

    // bits 7:0 form the DI byte, which goes out first
    typedef struct packed {
        logic [15:0] wc;
        logic [1:0]  vc;
        dsi_dt_e     dt;
    } pkt_long_t;

    typedef struct packed {
        logic [7:0] data1;
        logic [7:0] data0;
        logic [1:0] vc;
        dsi_dt_e    dt;
    } pkt_short_t;

    typedef union packed {
        pkt_long_t  long_h;
        pkt_short_t short_h;
    } pkt_hdr_u;

    typedef struct packed {
        pkt_hdr_u hdr;
        logic     is_long;
        logic     pixels;  // payload from pixel input
    } pkt_cmd_t;

    typedef struct packed {
        logic [31:0] data;    // byte 0 goes first
        logic [2:0]  nbytes;  // 1 to 4
    } word_t;

    localparam logic [7:0]  BLANK_BYTE = 8'h55;
    localparam logic [15:0] CRC_INIT   = 16'hFFFF;
    localparam logic [15:0] CRC_POLY   = 16'h8408;  // reflected x^16+x^12+x^5+1

    // hamming parity over header bits, d[7:0] is the DI byte
    function automatic logic [7:0] dsi_ecc(input logic [23:0] d);
        logic [7:0] p;
        p[0] = ^(d & 24'hF1_2CB7);
        p[1] = ^(d & 24'hF2_555B);
        p[2] = ^(d & 24'h74_9A6D);
        p[3] = ^(d & 24'hB8_E38E);
        p[4] = ^(d & 24'hDF_03F0);
        p[5] = ^(d & 24'hEF_FC00);
        p[7:6] = 2'b00;
        return p;
    endfunction

endpackage

//--- src/dsi_tx_top.sv
`timescale 1ns/1ps

module dsi_tx_top
    import dsi_pkt_pkg::*, dsi_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  apb_req_t               apb_req,
    output apb_rsp_t               apb_rsp,
    input  logic [31:0]            pix_data,
    input  logic                   pix_valid,
    output logic                   pix_ready,
    output logic [8*MAX_LANES-1:0] lane_data,
    output logic [MAX_LANES-1:0]   lane_write,
    input  logic [MAX_LANES-1:0]   lane_full
);

    dsi_timing_t timing;
    logic        stream_enable;
    logic [2:0]  lane_count;
    pkt_cmd_t    seq_cmd;
    logic        seq_valid;
    logic        seq_ready;
    pkt_cmd_t    bld_cmd;
    logic        bld_valid;
    logic        bld_ready;
    word_t       word;
    logic        word_valid;
    logic        word_ready;

    dsi_apb_regs i_dsi_apb_regs (
        .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .timing(timing), .stream_enable(stream_enable), .lane_count(lane_count)
    );

    dsi_frame_sequencer i_dsi_frame_sequencer (
        .clk(clk), .rst_n(rst_n), .timing(timing), .stream_enable(stream_enable),
        .cmd(seq_cmd), .cmd_valid(seq_valid), .cmd_ready(seq_ready)
    );

    dsi_cmd_fifo i_dsi_cmd_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_cmd(seq_cmd), .in_valid(seq_valid), .in_ready(seq_ready),
        .out_cmd(bld_cmd), .out_valid(bld_valid), .out_ready(bld_ready)
    );

    dsi_packet_builder i_dsi_packet_builder (
        .clk(clk), .rst_n(rst_n),
        .cmd(bld_cmd), .cmd_valid(bld_valid), .cmd_ready(bld_ready),
        .pix_data(pix_data), .pix_valid(pix_valid), .pix_ready(pix_ready),
        .word(word), .word_valid(word_valid), .word_ready(word_ready)
    );

    dsi_lane_repacker i_dsi_lane_repacker (
        .clk(clk), .rst_n(rst_n), .lane_count(lane_count),
        .word(word), .word_valid(word_valid), .word_ready(word_ready),
        .lane_data(lane_data), .lane_write(lane_write), .lane_full(lane_full)
    );

endmodule
